// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_datapath
FILELIST = project.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: project.f
rtl/mips_pkg.sv
rtl/pc_fetch.sv
rtl/inst_fifo.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/issue_stage.sv
rtl/alu.sv
rtl/exec_writeback.sv
rtl/datapath.sv
sim/tb_datapath.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu
	import mips_pkg::*;
(
	input  alu_op_t aluop,
	input  word_t   a,
	input  word_t   b,
	output word_t   y
);

	always_comb begin
		case (aluop)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or: y = a | b;
			alu_xor: y = a ^ b;
			// signed compare
			alu_slt: y = {31'b0, $signed(a) < $signed(b)};
			// shift amount comes in on a
			alu_sll: y = b << a[4:0];
			alu_lui: y = {b[15:0], 16'h0};
			default: y = '0;
		endcase
	end

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ps

module datapath
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_data_ok,
	input  logic      inst_data_ok1,
	input  logic      inst_data_ok2,
	input  inst_t     inst_rdata1,
	input  inst_t     inst_rdata2,
	output logic      inst_sram_en,
	output word_t     f_pc,
	// retire ports, straight from W
	output logic      w_master_wen, w_slave_wen,
	output reg_addr_t w_master_waddr, w_slave_waddr,
	output word_t     w_master_wdata, w_slave_wdata
);

	// fetch and queue
	logic fifo_wen1, fifo_wen2, pop_master, pop_slave;
	fifo_cnt_t fifo_count;
	inst_t head_inst, next_inst;
	word_t head_pc, next_pc;

	// register file reads
	reg_addr_t ra1_a, ra1_b, ra2_a, ra2_b;
	word_t rd1_a, rd1_b, rd2_a, rd2_b;

	// D to E registers
	logic e_master_valid, e_slave_valid;
	alu_op_t e_master_aluop, e_slave_aluop;
	word_t e_master_rs_value, e_slave_rs_value, e_master_rt_value, e_slave_rt_value;
	word_t e_master_imm_value, e_slave_imm_value;
	logic [4:0] e_master_shamt, e_slave_shamt;
	logic e_master_alu_sela, e_slave_alu_sela, e_master_alu_selb, e_slave_alu_selb;
	logic e_master_reg_wen, e_slave_reg_wen;
	reg_addr_t e_master_reg_waddr, e_slave_reg_waddr;

	// forwarding network
	logic fwd_e_master_wen, fwd_e_slave_wen, fwd_m_master_wen, fwd_m_slave_wen;
	reg_addr_t fwd_e_master_waddr, fwd_e_slave_waddr;
	reg_addr_t fwd_m_master_waddr, fwd_m_slave_waddr;
	word_t fwd_e_master_wdata, fwd_e_slave_wdata, fwd_m_master_wdata, fwd_m_slave_wdata;

	pc_fetch u_pc_fetch (.*);

	inst_fifo u_inst_fifo (
		.wen1   (fifo_wen1),
		.wen2   (fifo_wen2),
		.wpc    (f_pc),
		.wdata1 (inst_rdata1),
		.wdata2 (inst_rdata2),
		.count  (fifo_count),
		.*
	);

	issue_stage u_issue_stage (.*);

	exec_writeback u_exec_writeback (.*);

	regfile u_regfile (
		.wen1 (w_master_wen),
		.wa1  (w_master_waddr),
		.wd1  (w_master_wdata),
		.wen2 (w_slave_wen),
		.wa2  (w_slave_waddr),
		.wd2  (w_slave_wdata),
		.*
	);

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder
	import mips_pkg::*;
(
	input  inst_t      instr,
	output reg_addr_t  rs,
	output reg_addr_t  rt,
	output reg_addr_t  reg_waddr,
	output logic       reg_wen,
	output alu_op_t    aluop,
	output word_t      imm_value,
	output logic [4:0] shamt,
	output logic       alu_sela,
	output logic       alu_selb
);

	logic [5:0] op, funct;
	logic [15:0] imm;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];
	assign imm = instr[15:0];

	always_comb begin
		aluop = alu_nop;
		alu_sela = 1'b0;
		alu_selb = 1'b1;
		reg_waddr = rt;
		imm_value = {{16{imm[15]}}, imm};
		case (op)
			OP_SPECIAL: begin
				alu_selb = 1'b0;
				reg_waddr = instr[15:11];
				case (funct)
					FN_SLL: begin
						aluop = alu_sll;
						alu_sela = 1'b1;
					end
					FN_ADDU: aluop = alu_add;
					FN_SUBU: aluop = alu_sub;
					FN_AND: aluop = alu_and;
					FN_OR: aluop = alu_or;
					FN_XOR: aluop = alu_xor;
					FN_SLT: aluop = alu_slt;
					default: aluop = alu_nop;
				endcase
			end
			OP_ADDIU: aluop = alu_add;
			OP_SLTI: aluop = alu_slt;
			// logical immediates are zero extended
			OP_ANDI: begin
				aluop = alu_and;
				imm_value = {16'h0, imm};
			end
			OP_ORI: begin
				aluop = alu_or;
				imm_value = {16'h0, imm};
			end
			OP_XORI: begin
				aluop = alu_xor;
				imm_value = {16'h0, imm};
			end
			OP_LUI: begin
				aluop = alu_lui;
				imm_value = {16'h0, imm};
			end
			default: aluop = alu_nop;
		endcase
	end

	// unknown encodings and $0 targets write nothing
	assign reg_wen = (aluop != alu_nop) && (reg_waddr != '0);

endmodule

// File: rtl/exec_writeback.sv
`timescale 1ns/1ps

module exec_writeback
	import mips_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       e_master_valid, e_slave_valid,
	input  alu_op_t    e_master_aluop, e_slave_aluop,
	input  word_t      e_master_rs_value, e_slave_rs_value,
	input  word_t      e_master_rt_value, e_slave_rt_value,
	input  word_t      e_master_imm_value, e_slave_imm_value,
	input  logic [4:0] e_master_shamt, e_slave_shamt,
	input  logic       e_master_alu_sela, e_slave_alu_sela,
	input  logic       e_master_alu_selb, e_slave_alu_selb,
	input  logic       e_master_reg_wen, e_slave_reg_wen,
	input  reg_addr_t  e_master_reg_waddr, e_slave_reg_waddr,
	output logic       fwd_e_master_wen, fwd_e_slave_wen,
	output reg_addr_t  fwd_e_master_waddr, fwd_e_slave_waddr,
	output word_t      fwd_e_master_wdata, fwd_e_slave_wdata,
	output logic       fwd_m_master_wen, fwd_m_slave_wen,
	output reg_addr_t  fwd_m_master_waddr, fwd_m_slave_waddr,
	output word_t      fwd_m_master_wdata, fwd_m_slave_wdata,
	output logic       w_master_wen, w_slave_wen,
	output reg_addr_t  w_master_waddr, w_slave_waddr,
	output word_t      w_master_wdata, w_slave_wdata
);

	word_t m_srca, m_srcb, s_srca, s_srcb;

	// a is shamt for sll, b is the immediate for I-type
	assign m_srca = e_master_alu_sela ? {27'b0, e_master_shamt} : e_master_rs_value;
	assign m_srcb = e_master_alu_selb ? e_master_imm_value : e_master_rt_value;
	assign s_srca = e_slave_alu_sela ? {27'b0, e_slave_shamt} : e_slave_rs_value;
	assign s_srcb = e_slave_alu_selb ? e_slave_imm_value : e_slave_rt_value;

	alu u_alu_master (
		.aluop (e_master_aluop),
		.a     (m_srca),
		.b     (m_srcb),
		.y     (fwd_e_master_wdata)
	);

	alu u_alu_slave (
		.aluop (e_slave_aluop),
		.a     (s_srca),
		.b     (s_srcb),
		.y     (fwd_e_slave_wdata)
	);

	assign fwd_e_master_wen = e_master_valid & e_master_reg_wen;
	assign fwd_e_master_waddr = e_master_reg_waddr;
	assign fwd_e_slave_wen = e_slave_valid & e_slave_reg_wen;
	assign fwd_e_slave_waddr = e_slave_reg_waddr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fwd_m_master_wen <= 1'b0;
			fwd_m_slave_wen <= 1'b0;
			w_master_wen <= 1'b0;
			w_slave_wen <= 1'b0;
		end else begin
			fwd_m_master_wen <= fwd_e_master_wen;
			fwd_m_slave_wen <= fwd_e_slave_wen;
			w_master_wen <= fwd_m_master_wen;
			w_slave_wen <= fwd_m_slave_wen;
		end
	end

	// M holds results only, nothing left to do there
	always_ff @(posedge clk) begin
		fwd_m_master_waddr <= fwd_e_master_waddr;
		fwd_m_master_wdata <= fwd_e_master_wdata;
		fwd_m_slave_waddr <= fwd_e_slave_waddr;
		fwd_m_slave_wdata <= fwd_e_slave_wdata;
		w_master_waddr <= fwd_m_master_waddr;
		w_master_wdata <= fwd_m_master_wdata;
		w_slave_waddr <= fwd_m_slave_waddr;
		w_slave_wdata <= fwd_m_slave_wdata;
	end

endmodule

// File: rtl/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      wen1,
	input  logic      wen2,
	input  word_t     wpc,
	input  inst_t     wdata1,
	input  inst_t     wdata2,
	input  logic      pop_master,
	input  logic      pop_slave,
	output inst_t     head_inst,
	output inst_t     next_inst,
	output word_t     head_pc,
	output word_t     next_pc,
	output fifo_cnt_t count
);

	inst_t inst_mem [FIFO_DEPTH];
	word_t pc_mem [FIFO_DEPTH];
	fifo_ptr_t wptr, rptr;
	fifo_ptr_t wptr_second, rptr_second;
	fifo_cnt_t n_write, n_pop;

	assign n_write = fifo_cnt_t'(wen1) + fifo_cnt_t'(wen2);
	assign n_pop = fifo_cnt_t'(pop_master) + fifo_cnt_t'(pop_slave);
	assign wptr_second = wptr + 1'b1;
	assign rptr_second = rptr + 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			wptr <= wptr + fifo_ptr_t'(n_write);
			rptr <= rptr + fifo_ptr_t'(n_pop);
			count <= count + n_write - n_pop;
		end
	end

	// word 2 lands right behind word 1
	always_ff @(posedge clk) begin
		if (wen1) begin
			inst_mem[wptr] <= wdata1;
			pc_mem[wptr] <= wpc;
		end
		if (wen2) begin
			inst_mem[wptr_second] <= wdata2;
			pc_mem[wptr_second] <= wpc + 32'd4;
		end
	end

	assign head_inst = inst_mem[rptr];
	assign head_pc = pc_mem[rptr];
	assign next_inst = inst_mem[rptr_second];
	assign next_pc = pc_mem[rptr_second];

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		count + n_write <= fifo_cnt_t'(FIFO_DEPTH))
		else $error("instruction queue overflow");

	a_slave_after_master: assert property (@(posedge clk) disable iff (!rst_n)
		pop_slave |-> pop_master)
		else $error("slave popped without master");

endmodule

// File: rtl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage
	import mips_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  inst_t      head_inst,
	input  inst_t      next_inst,
	input  word_t      head_pc,
	input  word_t      next_pc,
	input  fifo_cnt_t  fifo_count,
	input  word_t      rd1_a, rd1_b, rd2_a, rd2_b,
	// results still in flight in E and M
	input  logic       fwd_e_master_wen, fwd_e_slave_wen,
	input  reg_addr_t  fwd_e_master_waddr, fwd_e_slave_waddr,
	input  word_t      fwd_e_master_wdata, fwd_e_slave_wdata,
	input  logic       fwd_m_master_wen, fwd_m_slave_wen,
	input  reg_addr_t  fwd_m_master_waddr, fwd_m_slave_waddr,
	input  word_t      fwd_m_master_wdata, fwd_m_slave_wdata,
	output logic       pop_master, pop_slave,
	output reg_addr_t  ra1_a, ra1_b, ra2_a, ra2_b,
	output logic       e_master_valid, e_slave_valid,
	output alu_op_t    e_master_aluop, e_slave_aluop,
	output word_t      e_master_rs_value, e_slave_rs_value,
	output word_t      e_master_rt_value, e_slave_rt_value,
	output word_t      e_master_imm_value, e_slave_imm_value,
	output logic [4:0] e_master_shamt, e_slave_shamt,
	output logic       e_master_alu_sela, e_slave_alu_sela,
	output logic       e_master_alu_selb, e_slave_alu_selb,
	output logic       e_master_reg_wen, e_slave_reg_wen,
	output reg_addr_t  e_master_reg_waddr, e_slave_reg_waddr
);

	reg_addr_t m_waddr, s_waddr;
	logic m_wen, s_wen, m_sela, s_sela, m_selb, s_selb;
	alu_op_t m_aluop, s_aluop;
	word_t m_imm, s_imm;
	logic [4:0] m_shamt, s_shamt;
	word_t m_rs_value, m_rt_value, s_rs_value, s_rt_value;
	logic slave_ok;

	decoder u_decoder_master (
		.instr     (head_inst),
		.rs        (ra1_a),
		.rt        (ra1_b),
		.reg_waddr (m_waddr),
		.reg_wen   (m_wen),
		.aluop     (m_aluop),
		.imm_value (m_imm),
		.shamt     (m_shamt),
		.alu_sela  (m_sela),
		.alu_selb  (m_selb)
	);

	decoder u_decoder_slave (
		.instr     (next_inst),
		.rs        (ra2_a),
		.rt        (ra2_b),
		.reg_waddr (s_waddr),
		.reg_wen   (s_wen),
		.aluop     (s_aluop),
		.imm_value (s_imm),
		.shamt     (s_shamt),
		.alu_sela  (s_sela),
		.alu_selb  (s_selb)
	);

	// youngest producer wins: E before M, slave before master
	function automatic word_t forward(input reg_addr_t addr, input word_t rf_data);
		word_t value;
		if (fwd_e_slave_wen && fwd_e_slave_waddr == addr) begin
			value = fwd_e_slave_wdata;
		end else if (fwd_e_master_wen && fwd_e_master_waddr == addr) begin
			value = fwd_e_master_wdata;
		end else if (fwd_m_slave_wen && fwd_m_slave_waddr == addr) begin
			value = fwd_m_slave_wdata;
		end else if (fwd_m_master_wen && fwd_m_master_waddr == addr) begin
			value = fwd_m_master_wdata;
		end else begin
			value = rf_data;
		end
		return value;
	endfunction

	always_comb begin
		m_rs_value = forward(ra1_a, rd1_a);
		m_rt_value = forward(ra1_b, rd1_b);
		s_rs_value = forward(ra2_a, rd2_a);
		s_rt_value = forward(ra2_b, rd2_b);
	end

	// m_wen already excludes $0 as destination
	assign slave_ok = (fifo_count >= fifo_cnt_t'(2)) && m_wen &&
		(ra2_a != m_waddr) && (ra2_b != m_waddr);
	assign pop_master = fifo_count != '0;
	assign pop_slave = pop_master && slave_ok;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_master_valid <= 1'b0;
			e_master_reg_wen <= 1'b0;
			e_slave_valid <= 1'b0;
			e_slave_reg_wen <= 1'b0;
		end else begin
			// a slot left out becomes a bubble
			e_master_valid <= pop_master;
			e_master_reg_wen <= pop_master & m_wen;
			e_slave_valid <= pop_slave;
			e_slave_reg_wen <= pop_slave & s_wen;
		end
	end

	always_ff @(posedge clk) begin
		e_master_aluop <= m_aluop;
		e_master_rs_value <= m_rs_value;
		e_master_rt_value <= m_rt_value;
		e_master_imm_value <= m_imm;
		e_master_shamt <= m_shamt;
		e_master_alu_sela <= m_sela;
		e_master_alu_selb <= m_selb;
		e_master_reg_waddr <= m_waddr;
		e_slave_aluop <= s_aluop;
		e_slave_rs_value <= s_rs_value;
		e_slave_rt_value <= s_rt_value;
		e_slave_imm_value <= s_imm;
		e_slave_shamt <= s_shamt;
		e_slave_alu_sela <= s_sela;
		e_slave_alu_selb <= s_selb;
		e_slave_reg_waddr <= s_waddr;
	end

	// no branches, so a dual-issued pair is always sequential
	a_pair_sequential: assert property (@(posedge clk) disable iff (!rst_n)
		pop_slave |-> next_pc == head_pc + 32'd4)
		else $error("dual issue of a non-sequential pair");

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] inst_t;

	// instruction queue geometry
	localparam int FIFO_DEPTH = 8;
	typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH):0] fifo_cnt_t;

	localparam word_t RESET_PC = 32'h0000_0000;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_XORI = 6'b001110;
	localparam logic [5:0] OP_LUI = 6'b001111;

	// funct field under OP_SPECIAL
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_SLT = 6'b101010;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_lui,
		alu_nop
	} alu_op_t;

	typedef enum logic {
		fetch_idle,
		fetch_wait
	} fetch_state_t;

endpackage

// File: rtl/pc_fetch.sv
`timescale 1ns/1ps

module pc_fetch
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_data_ok,
	input  logic      inst_data_ok1,
	input  logic      inst_data_ok2,
	input  fifo_cnt_t fifo_count,
	output logic      inst_sram_en,
	output word_t     f_pc,
	output logic      fifo_wen1,
	output logic      fifo_wen2
);

	fetch_state_t state;
	logic room;
	word_t pc_step;

	// a pair must fit before asking for one
	assign room = fifo_count <= fifo_cnt_t'(FIFO_DEPTH - 2);

	// ok2 implies ok1
	assign pc_step = inst_data_ok2 ? 32'd8 : (inst_data_ok1 ? 32'd4 : 32'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= fetch_idle;
			f_pc <= RESET_PC;
		end else if (state == fetch_idle) begin
			if (room) begin
				state <= fetch_wait;
			end
		end else if (inst_data_ok) begin
			state <= fetch_idle;
			f_pc <= f_pc + pc_step;
		end
	end

	// request held high until the response pulse
	assign inst_sram_en = state == fetch_wait;
	assign fifo_wen1 = inst_data_ok & inst_data_ok1;
	assign fifo_wen2 = inst_data_ok & inst_data_ok2;

	a_ok2_needs_ok1: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_data_ok && inst_data_ok2) |-> inst_data_ok1)
		else $error("second word returned without the first");

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t ra1_a, ra1_b, ra2_a, ra2_b,
	input  logic      wen1, wen2,
	input  reg_addr_t wa1, wa2,
	input  word_t     wd1, wd2,
	output word_t     rd1_a, rd1_b, rd2_a, rd2_b
);

	word_t regs [32];

	// same-cycle writes pass straight through, slave first
	function automatic word_t read_port(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wen2 && wa2 == addr) begin
			value = wd2;
		end else if (wen1 && wa1 == addr) begin
			value = wd1;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rd1_a = read_port(ra1_a);
		rd1_b = read_port(ra1_b);
		rd2_a = read_port(ra2_a);
		rd2_b = read_port(ra2_b);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wen1 && wa1 != '0) begin
				regs[wa1] <= wd1;
			end
			// slave is younger, its write lands last
			if (wen2 && wa2 != '0) begin
				regs[wa2] <= wd2;
			end
		end
	end

endmodule

// File: sim/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath
	import mips_pkg::*;
();

	localparam int RANDOM_LEN = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic inst_data_ok = 1'b0;
	logic inst_data_ok1 = 1'b0;
	logic inst_data_ok2 = 1'b0;
	inst_t inst_rdata1 = '0;
	inst_t inst_rdata2 = '0;
	logic inst_sram_en;
	word_t f_pc;
	logic w_master_wen, w_slave_wen;
	reg_addr_t w_master_waddr, w_slave_waddr;
	word_t w_master_wdata, w_slave_wdata;

	inst_t prog [$];
	reg_addr_t exp_addr [$];
	word_t exp_data [$];
	int exp_idx [$];
	word_t fetch_pc;
	logic pending;
	int delay;
	logic two_words;
	int m_idx, s_idx;
	int dual_count = 0;

	always #2 clk = ~clk;

	datapath u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.inst_data_ok   (inst_data_ok),
		.inst_data_ok1  (inst_data_ok1),
		.inst_data_ok2  (inst_data_ok2),
		.inst_rdata1    (inst_rdata1),
		.inst_rdata2    (inst_rdata2),
		.inst_sram_en   (inst_sram_en),
		.f_pc           (f_pc),
		.w_master_wen   (w_master_wen),
		.w_slave_wen    (w_slave_wen),
		.w_master_waddr (w_master_waddr),
		.w_slave_waddr  (w_slave_waddr),
		.w_master_wdata (w_master_wdata),
		.w_slave_wdata  (w_slave_wdata)
	);

	task automatic halt(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			halt($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	function automatic inst_t enc_r(input logic [5:0] fn, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt, input logic [4:0] sa);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic inst_t enc_i(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ISA semantics with a as the rs value and b as the rt value
	function automatic logic ref_exec(input inst_t instr, input word_t a, input word_t b,
			output reg_addr_t dest, output word_t value);
		logic [5:0] op;
		word_t simm, zimm;
		logic writes;
		op = instr[31:26];
		simm = {{16{instr[15]}}, instr[15:0]};
		zimm = {16'h0, instr[15:0]};
		writes = 1'b1;
		dest = instr[20:16];
		value = '0;
		if (op == OP_SPECIAL) begin
			dest = instr[15:11];
			case (instr[5:0])
				FN_SLL: value = b << instr[10:6];
				FN_ADDU: value = a + b;
				FN_SUBU: value = a - b;
				FN_AND: value = a & b;
				FN_OR: value = a | b;
				FN_XOR: value = a ^ b;
				FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: writes = 1'b0;
			endcase
		end else begin
			case (op)
				OP_ADDIU: value = a + simm;
				OP_SLTI: value = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
				OP_ANDI: value = a & zimm;
				OP_ORI: value = a | zimm;
				OP_XORI: value = a ^ zimm;
				OP_LUI: value = {instr[15:0], 16'h0};
				default: writes = 1'b0;
			endcase
		end
		return writes && dest != 5'd0;
	endfunction

	// small register range keeps dependencies dense
	function automatic inst_t random_inst();
		int kind;
		reg_addr_t rd, rs, rt;
		logic [15:0] imm;
		inst_t instr;
		kind = $urandom_range(0, 13);
		rd = reg_addr_t'($urandom_range(0, 7));
		rs = reg_addr_t'($urandom_range(0, 7));
		rt = reg_addr_t'($urandom_range(0, 7));
		imm = 16'($urandom());
		case (kind)
			0: instr = enc_r(FN_ADDU, rd, rs, rt, 5'd0);
			1: instr = enc_r(FN_SUBU, rd, rs, rt, 5'd0);
			2: instr = enc_r(FN_AND, rd, rs, rt, 5'd0);
			3: instr = enc_r(FN_OR, rd, rs, rt, 5'd0);
			4: instr = enc_r(FN_XOR, rd, rs, rt, 5'd0);
			5: instr = enc_r(FN_SLT, rd, rs, rt, 5'd0);
			6: instr = enc_r(FN_SLL, rd, 5'd0, rt, imm[4:0]);
			7: instr = enc_i(OP_ADDIU, rt, rs, imm);
			8: instr = enc_i(OP_SLTI, rt, rs, imm);
			9: instr = enc_i(OP_ANDI, rt, rs, imm);
			10: instr = enc_i(OP_ORI, rt, rs, imm);
			11: instr = enc_i(OP_XORI, rt, rs, imm);
			12: instr = enc_i(OP_LUI, rt, 5'd0, imm);
			// load word lies outside the subset
			default: instr = {6'b100011, rs, rt, imm};
		endcase
		return instr;
	endfunction

	task automatic build_program();
		// independent ops covering every kept opcode
		prog.push_back(enc_i(OP_LUI, 5'd1, 5'd0, 16'h8001));
		prog.push_back(enc_i(OP_ORI, 5'd2, 5'd0, 16'h1234));
		prog.push_back(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'hfffb));
		prog.push_back(enc_i(OP_XORI, 5'd4, 5'd0, 16'h00ff));
		prog.push_back(enc_r(FN_ADDU, 5'd6, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(FN_SUBU, 5'd7, 5'd3, 5'd4, 5'd0));
		prog.push_back(enc_r(FN_AND, 5'd8, 5'd1, 5'd3, 5'd0));
		prog.push_back(enc_r(FN_OR, 5'd9, 5'd2, 5'd4, 5'd0));
		prog.push_back(enc_r(FN_XOR, 5'd10, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(FN_SLT, 5'd11, 5'd3, 5'd2, 5'd0));
		prog.push_back(enc_r(FN_SLL, 5'd12, 5'd0, 5'd2, 5'd4));
		prog.push_back(enc_i(OP_SLTI, 5'd13, 5'd3, 16'hffff));
		prog.push_back(enc_i(OP_ANDI, 5'd14, 5'd3, 16'h0ff0));
		// slave reads master destination
		prog.push_back(enc_i(OP_ADDIU, 5'd15, 5'd0, 16'h0007));
		prog.push_back(enc_r(FN_ADDU, 5'd16, 5'd15, 5'd15, 5'd0));
		// distances 1, 2 and 3
		prog.push_back(enc_i(OP_ADDIU, 5'd17, 5'd0, 16'h0003));
		prog.push_back(enc_r(FN_ADDU, 5'd18, 5'd17, 5'd17, 5'd0));
		prog.push_back(enc_i(OP_ORI, 5'd19, 5'd0, 16'h0001));
		prog.push_back(enc_r(FN_SUBU, 5'd20, 5'd18, 5'd17, 5'd0));
		prog.push_back(enc_r(FN_XOR, 5'd21, 5'd20, 5'd18, 5'd0));
		// same destination in one pair followed by a reader
		prog.push_back(enc_i(OP_ADDIU, 5'd22, 5'd0, 16'h0011));
		prog.push_back(enc_r(FN_ADDU, 5'd22, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(FN_OR, 5'd24, 5'd22, 5'd0, 5'd0));
		// writes to $0 and unknown encodings retire nothing
		prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
		prog.push_back(32'h8c22_0004);
		for (int i = 0; i < RANDOM_LEN; i++) begin
			prog.push_back(random_inst());
		end
	endtask

	task automatic build_expected();
		word_t model [32];
		reg_addr_t d;
		word_t v;
		for (int r = 0; r < 32; r++) begin
			model[r] = '0;
		end
		for (int i = 0; i < prog.size(); i++) begin
			if (ref_exec(prog[i], model[prog[i][25:21]], model[prog[i][20:16]], d, v)) begin
				model[d] = v;
				exp_addr.push_back(d);
				exp_data.push_back(v);
				exp_idx.push_back(i);
			end
		end
	endtask

	// zero words past the end decode as no-ops
	function automatic inst_t mem_word(input word_t addr);
		if ((addr >> 2) < word_t'(prog.size())) begin
			return prog[addr >> 2];
		end
		return '0;
	endfunction

	// instruction memory serving one request at a time
	always @(negedge clk) begin
		if (!rst_n) begin
			pending = 1'b0;
			delay = 0;
			fetch_pc = '0;
			inst_data_ok <= 1'b0;
			inst_data_ok1 <= 1'b0;
			inst_data_ok2 <= 1'b0;
		end else if (inst_data_ok) begin
			pending = 1'b0;
			inst_data_ok <= 1'b0;
			inst_data_ok1 <= 1'b0;
			inst_data_ok2 <= 1'b0;
		end else if (pending) begin
			check_val("inst_sram_en", 32'(inst_sram_en), 32'd1);
			check_val("f_pc", f_pc, fetch_pc);
			delay = delay - 1;
			if (delay == 0) begin
				two_words = $urandom_range(0, 3) != 0;
				inst_data_ok <= 1'b1;
				inst_data_ok1 <= 1'b1;
				inst_data_ok2 <= two_words;
				inst_rdata1 <= mem_word(fetch_pc);
				inst_rdata2 <= two_words ? mem_word(fetch_pc + 32'd4) : $urandom();
				fetch_pc = fetch_pc + (two_words ? 32'd8 : 32'd4);
			end
		end else if (inst_sram_en) begin
			check_val("f_pc", f_pc, fetch_pc);
			pending = 1'b1;
			delay = $urandom_range(1, 4);
		end
	end

	task automatic take_retire(input string port, input reg_addr_t addr, input word_t data,
			output int idx);
		if (exp_addr.size() == 0) begin
			halt($sformatf("a write retired on the %s port after the last expected one", port));
		end
		check_val({port, "_waddr"}, 32'(addr), 32'(exp_addr[0]));
		check_val({port, "_wdata"}, data, exp_data[0]);
		idx = exp_idx[0];
		void'(exp_addr.pop_front());
		void'(exp_data.pop_front());
		void'(exp_idx.pop_front());
	endtask

	// master retire is older than the slave retire
	always @(negedge clk) begin
		if (rst_n) begin
			if (w_master_wen) begin
				take_retire("w_master", w_master_waddr, w_master_wdata, m_idx);
			end
			if (w_slave_wen) begin
				take_retire("w_slave", w_slave_waddr, w_slave_wdata, s_idx);
			end
			if (w_master_wen && w_slave_wen) begin
				dual_count++;
				check_val("slave_index", 32'(s_idx), 32'(m_idx + 1));
				if (prog[s_idx][25:21] == w_master_waddr ||
						prog[s_idx][20:16] == w_master_waddr) begin
					halt("a slave that reads the master destination issued with it");
				end
			end
		end
	end

	task automatic wait_first_fetch();
		int n;
		n = 0;
		while (!inst_sram_en) begin
			@(negedge clk);
			n++;
			if (n > 8) begin
				halt("no fetch request after reset");
			end
		end
		check_val("f_pc", f_pc, 32'h0);
	endtask

	task automatic wait_all_retired();
		int n;
		n = 0;
		while (exp_addr.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > 4000) begin
				halt($sformatf("timed out with %0d writes still expected", exp_addr.size()));
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		void'($urandom(32'he491_a61e));
		build_program();
		build_expected();
		repeat (4) begin
			@(negedge clk);
			check_val("inst_sram_en", 32'(inst_sram_en), 32'd0);
			check_val("w_master_wen", 32'(w_master_wen), 32'd0);
			check_val("w_slave_wen", 32'(w_slave_wen), 32'd0);
		end
		rst_n = 1'b1;
		wait_first_fetch();
		wait_all_retired();
		if (dual_count == 0) begin
			halt("no cycle retired writes on both ports");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule
